/* include/obi_mem_params.svh */
// OBI memory parameters

`ifndef OBI_MEM_PARAMS_SVH
`define OBI_MEM_PARAMS_SVH

// --------------------
// Bus widths
// --------------------
// Byte address width
`define OBI_ADDR_W      16
// Data word width
`define OBI_DATA_W      32
// One enable per data byte
`define OBI_BE_W        4

// --------------------
// Bank layout
// --------------------
`define OBI_NUM_BANKS   4
`define OBI_BANK_WORDS  64
// Index widths, log2 of the two counts above
`define OBI_BANK_IDX_W  2
`define OBI_WORD_IDX_W  6

`endif

/* hdl/obi_mem_pkg.sv */
// OBI memory types

`include "obi_mem_params.svh"

package obi_mem_pkg;

    // --------------------
    // Bus payload types
    // --------------------
    // Byte address as issued by the master
    typedef logic [`OBI_ADDR_W-1:0]     obi_addr_t;

    // Read and write data word
    typedef logic [`OBI_DATA_W-1:0]     obi_data_t;

    // Byte enables, bit n covers data byte n
    typedef logic [`OBI_BE_W-1:0]       obi_be_t;

    // --------------------
    // Address map fields
    // --------------------
    // Bank number, taken from the bits above the word index
    typedef logic [`OBI_BANK_IDX_W-1:0] bank_idx_t;

    // Word number inside one bank
    typedef logic [`OBI_WORD_IDX_W-1:0] word_idx_t;

endpackage : obi_mem_pkg

/* hdl/obi_addr_decoder.sv */
// OBI address decoder

`timescale 1ns/10ps

`include "obi_mem_params.svh"

module obi_addr_decoder (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Master request
    input  logic                   req_i,
    input  obi_mem_pkg::obi_addr_t addr_i,
    input  logic                   we_i,
    input  obi_mem_pkg::obi_be_t   be_i,
    input  obi_mem_pkg::obi_data_t wdata_i,
    output logic                   gnt_o,
    // Bank side
    input  logic                   bank_gnt_i [`OBI_NUM_BANKS],
    output logic                   bank_req_o [`OBI_NUM_BANKS],
    output obi_mem_pkg::word_idx_t bank_word_o,
    output logic                   bank_we_o,
    output obi_mem_pkg::obi_be_t   bank_be_o,
    output obi_mem_pkg::obi_data_t bank_wdata_o,
    // To the response mux
    output logic                   err_strobe_o
);

    // Lowest address bit above the mapped region
    localparam int HI_LSB = `OBI_WORD_IDX_W + `OBI_BANK_IDX_W + 2;

    obi_mem_pkg::bank_idx_t bank_sel;
    logic                   unmapped;
    logic                   err_q;

    // --------------------
    // Address split
    // --------------------
    // Bits 1..0 are the byte offset and are dropped
    assign bank_word_o = addr_i[`OBI_WORD_IDX_W+1:2];
    assign bank_sel    = addr_i[HI_LSB-1:`OBI_WORD_IDX_W+2];
    // Any upper bit set falls outside every bank
    assign unmapped    = |addr_i[`OBI_ADDR_W-1:HI_LSB];

    // Write payload is shared by all banks
    assign bank_we_o    = we_i;
    assign bank_be_o    = be_i;
    assign bank_wdata_o = wdata_i;

    // --------------------
    // Request steering
    // --------------------
    always_comb begin
        for (int i = 0; i < `OBI_NUM_BANKS; i++) begin
            // Only the addressed bank sees req, never in reset
            bank_req_o[i] = req_i & ~rst_i & ~unmapped
                            & (bank_sel == obi_mem_pkg::bank_idx_t'(i));
        end
    end

    // Unmapped requests are always granted, otherwise follow the bank
    assign gnt_o = ~rst_i & (unmapped | bank_gnt_i[bank_sel]);

    // --------------------
    // Error strobe
    // --------------------
    // One cycle pulse after an unmapped accept, lines up with bank rvalid
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req_i & unmapped;
        end
    end

    assign err_strobe_o = err_q;

endmodule : obi_addr_decoder

/* hdl/obi_ram_bank.sv */
// OBI RAM bank

`timescale 1ns/10ps

`include "obi_mem_params.svh"

module obi_ram_bank (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Request from the decoder
    input  logic                   req_i,
    output logic                   gnt_o,
    input  obi_mem_pkg::word_idx_t word_i,
    input  logic                   we_i,
    input  obi_mem_pkg::obi_be_t   be_i,
    input  obi_mem_pkg::obi_data_t wdata_i,
    // Response to the mux
    output logic                   rvalid_o,
    output obi_mem_pkg::obi_data_t rdata_o
);

    // Storage array, contents survive reset
    obi_mem_pkg::obi_data_t mem_q [`OBI_BANK_WORDS];
    obi_mem_pkg::obi_data_t rdata_q;
    logic                   rvalid_q;
    logic                   recov_q;
    logic                   accept;

    // --------------------
    // Handshake
    // --------------------
    // Grant drops for one cycle while a write settles
    assign gnt_o  = ~recov_q;
    assign accept = req_i & gnt_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            recov_q  <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            recov_q  <= accept & we_i;
            // Response follows every accept by one cycle
            rvalid_q <= accept;
        end
    end

    // --------------------
    // Memory array
    // --------------------
    always_ff @(posedge clk_i) begin
        if (accept) begin
            // Old word is captured, a same cycle write is not visible
            rdata_q <= mem_q[word_i];
        end
        for (int b = 0; b < `OBI_BE_W; b++) begin
            // Byte lane update, disabled lanes keep their value
            if (accept && we_i && be_i[b]) begin
                mem_q[word_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;

endmodule : obi_ram_bank

/* hdl/obi_resp_mux.sv */
// OBI response mux

`timescale 1ns/10ps

`include "obi_mem_params.svh"

module obi_resp_mux (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Bank responses
    input  logic                   bank_rvalid_i [`OBI_NUM_BANKS],
    input  obi_mem_pkg::obi_data_t bank_rdata_i  [`OBI_NUM_BANKS],
    // Unmapped access from the decoder
    input  logic                   err_strobe_i,
    // Master response
    output logic                   rvalid_o,
    output obi_mem_pkg::obi_data_t rdata_o,
    output logic                   err_o
);

    obi_mem_pkg::obi_data_t sel_data;
    logic                   any_valid;
    obi_mem_pkg::obi_data_t rdata_q;
    logic                   rvalid_q;
    logic                   err_q;

    // --------------------
    // Source select
    // --------------------
    // At most one source is valid per cycle, so an OR of masked data works
    always_comb begin
        sel_data  = '0;
        any_valid = err_strobe_i;
        for (int i = 0; i < `OBI_NUM_BANKS; i++) begin
            if (bank_rvalid_i[i]) begin
                sel_data  = sel_data | bank_rdata_i[i];
                any_valid = 1'b1;
            end
        end
    end

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            rvalid_q <= any_valid;
            err_q    <= err_strobe_i;
        end
        // Error cycles carry zero since no bank is valid then
        rdata_q <= sel_data;
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;
    assign err_o    = err_q;

endmodule : obi_resp_mux

/* hdl/obi_mem_subsys.sv */
// OBI memory subsystem top

`timescale 1ns/10ps

`include "obi_mem_params.svh"

module obi_mem_subsys (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Master request
    input  logic                   req_i,
    input  obi_mem_pkg::obi_addr_t addr_i,
    input  logic                   we_i,
    input  obi_mem_pkg::obi_be_t   be_i,
    input  obi_mem_pkg::obi_data_t wdata_i,
    output logic                   gnt_o,
    // Master response, two cycles after accept
    output logic                   rvalid_o,
    output obi_mem_pkg::obi_data_t rdata_o,
    output logic                   err_o
);

    // Per bank handshake and response
    logic                   bank_req    [`OBI_NUM_BANKS];
    logic                   bank_gnt    [`OBI_NUM_BANKS];
    logic                   bank_rvalid [`OBI_NUM_BANKS];
    obi_mem_pkg::obi_data_t bank_rdata  [`OBI_NUM_BANKS];

    // Shared request payload
    obi_mem_pkg::word_idx_t bank_word;
    logic                   bank_we;
    obi_mem_pkg::obi_be_t   bank_be;
    obi_mem_pkg::obi_data_t bank_wdata;

    logic                   err_strobe;

    // --------------------
    // Decoder
    // --------------------
    obi_addr_decoder i_obi_addr_decoder (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (req_i),
        .addr_i       (addr_i),
        .we_i         (we_i),
        .be_i         (be_i),
        .wdata_i      (wdata_i),
        .gnt_o        (gnt_o),
        .bank_gnt_i   (bank_gnt),
        .bank_req_o   (bank_req),
        .bank_word_o  (bank_word),
        .bank_we_o    (bank_we),
        .bank_be_o    (bank_be),
        .bank_wdata_o (bank_wdata),
        .err_strobe_o (err_strobe)
    );

    // --------------------
    // RAM banks
    // --------------------
    for (genvar g = 0; g < `OBI_NUM_BANKS; g++) begin : g_bank
        obi_ram_bank i_obi_ram_bank (
            .clk_i    (clk_i),
            .rst_i    (rst_i),
            .req_i    (bank_req[g]),
            .gnt_o    (bank_gnt[g]),
            .word_i   (bank_word),
            .we_i     (bank_we),
            .be_i     (bank_be),
            .wdata_i  (bank_wdata),
            .rvalid_o (bank_rvalid[g]),
            .rdata_o  (bank_rdata[g])
        );
    end

    // Response collection and output register
    obi_resp_mux i_obi_resp_mux (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .bank_rvalid_i (bank_rvalid),
        .bank_rdata_i  (bank_rdata),
        .err_strobe_i  (err_strobe),
        .rvalid_o      (rvalid_o),
        .rdata_o       (rdata_o),
        .err_o         (err_o)
    );

endmodule : obi_mem_subsys

/* verification/obi_mem_subsys_sva.sv */
// OBI protocol checker

`timescale 1ns/10ps

module obi_mem_subsys_sva (
    input logic clk_i,
    input logic rst_i,
    input logic req_i,
    input logic gnt_o,
    input logic rvalid_o,
    input logic err_o
);

    // Count of failed checks
    int   fail_cnt = 0;
    logic accept;

    assign accept = req_i & gnt_o;

    // --------------------
    // Response timing
    // --------------------
    // Fixed latency of two cycles from accept to response
    accept_to_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
        accept |-> ##2 rvalid_o)
        else begin
            fail_cnt++;
            $error("accept not followed by rvalid_o two cycles later");
        end

    // Every response belongs to an accept
    rvalid_has_accept: assert property (@(posedge clk_i) disable iff (rst_i)
        rvalid_o |-> $past(accept, 2))
        else begin
            fail_cnt++;
            $error("rvalid_o without a matching accept");
        end

    // Error only rides on a valid response
    err_needs_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
        err_o |-> rvalid_o)
        else begin
            fail_cnt++;
            $error("err_o high while rvalid_o is low");
        end

    // --------------------
    // Reset
    // --------------------
    // Response register needs one edge to clear
    quiet_in_reset: assert property (@(posedge clk_i)
        rst_i && $past(rst_i) |-> !gnt_o && !rvalid_o)
        else begin
            fail_cnt++;
            $error("gnt_o or rvalid_o active during reset");
        end

endmodule : obi_mem_subsys_sva

bind obi_mem_subsys obi_mem_subsys_sva i_obi_mem_subsys_sva (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (req_i),
    .gnt_o    (gnt_o),
    .rvalid_o (rvalid_o),
    .err_o    (err_o)
);

/* verification/tb_obi_mem_subsys.sv */
// OBI memory subsystem testbench

`timescale 1ns/10ps

`include "obi_mem_params.svh"

module tb_obi_mem_subsys;

    localparam int CLK_PERIOD  = 100;
    localparam int RST_CYCLES  = 8;
    // Preload plus directed and random transactions
    localparam int NUM_TXN     = 300;
    localparam int WATCHDOG_NS = (NUM_TXN * 4 + RST_CYCLES + 20) * CLK_PERIOD;
    localparam int MEM_WORDS   = `OBI_NUM_BANKS * `OBI_BANK_WORDS;

    logic                   clk_i;
    logic                   rst_i;
    logic                   req_i;
    obi_mem_pkg::obi_addr_t addr_i;
    logic                   we_i;
    obi_mem_pkg::obi_be_t   be_i;
    obi_mem_pkg::obi_data_t wdata_i;
    logic                   gnt_o;
    logic                   rvalid_o;
    obi_mem_pkg::obi_data_t rdata_o;
    logic                   err_o;

    // Reference memory indexed by bank and word
    obi_mem_pkg::obi_data_t ref_mem [MEM_WORDS];
    // Expected responses in acceptance order
    obi_mem_pkg::obi_data_t exp_data_q [$];
    bit                     exp_err_q  [$];
    bit                     exp_chk_q  [$];
    obi_mem_pkg::obi_data_t e_data;
    bit                     e_err;
    bit                     e_chk;
    integer                 seed;
    logic [31:0]            rnd;
    int                     waits;
    int                     word_sel [`OBI_NUM_BANKS];

    obi_mem_subsys i_obi_mem_subsys (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .req_i    (req_i),
        .addr_i   (addr_i),
        .we_i     (we_i),
        .be_i     (be_i),
        .wdata_i  (wdata_i),
        .gnt_o    (gnt_o),
        .rvalid_o (rvalid_o),
        .rdata_o  (rdata_o),
        .err_o    (err_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // --------------------
    // Helpers
    // --------------------
    function automatic obi_mem_pkg::obi_addr_t mk_addr(input int bank, input int word);
        return obi_mem_pkg::obi_addr_t'({bank[1:0], word[5:0], 2'b00});
    endfunction

    // Enabled byte lanes take the new data
    function automatic obi_mem_pkg::obi_data_t merge_bytes(input obi_mem_pkg::obi_data_t old_w,
            input obi_mem_pkg::obi_data_t new_w, input obi_mem_pkg::obi_be_t be);
        obi_mem_pkg::obi_data_t res;
        res = old_w;
        for (int b = 0; b < `OBI_BE_W; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "Simulation stopped on the first failed check");
    endtask

    // Hold one request until granted
    // Cycles with gnt_o low are counted in waits
    task automatic issue(input obi_mem_pkg::obi_addr_t addr, input logic we,
            input obi_mem_pkg::obi_be_t be, input obi_mem_pkg::obi_data_t data);
        logic accepted;
        req_i   = 1'b1;
        addr_i  = addr;
        we_i    = we;
        be_i    = be;
        wdata_i = data;
        waits   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk_i);
            accepted = gnt_o;
            if (!accepted) begin
                waits++;
            end
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic idle();
        req_i = 1'b0;
        @(posedge clk_i);
        #1;
    endtask

    // --------------------
    // Monitor
    // --------------------
    // Sampled mid cycle where inputs and gnt_o have settled
    always @(negedge clk_i) begin
        if (rst_i) begin
            assert (gnt_o === 1'b0 && rvalid_o === 1'b0 && err_o === 1'b0)
            else fail_run($sformatf("Error: gnt_o/rvalid_o/err_o expected 0/0/0 actual %h/%h/%h",
                                    gnt_o, rvalid_o, err_o));
        end
        if (rvalid_o === 1'b1) begin
            if (exp_err_q.size() == 0) begin
                fail_run("A response arrived with no request outstanding");
            end else begin
                e_data = exp_data_q.pop_front();
                e_err  = exp_err_q.pop_front();
                e_chk  = exp_chk_q.pop_front();
                assert (err_o === e_err)
                else fail_run($sformatf("Error: err_o expected %h actual %h", e_err, err_o));
                // Write responses carry no defined data
                assert (!e_chk || rdata_o === e_data)
                else fail_run($sformatf("Error: rdata_o expected %h actual %h", e_data, rdata_o));
            end
        end
        // Accept happens on the coming rising edge
        if (!rst_i && req_i && gnt_o) begin
            if (|addr_i[`OBI_ADDR_W-1:10]) begin
                exp_data_q.push_back('0);
                exp_err_q.push_back(1'b1);
                exp_chk_q.push_back(1'b1);
            end else begin
                exp_data_q.push_back(ref_mem[addr_i[9:2]]);
                exp_err_q.push_back(1'b0);
                exp_chk_q.push_back(!we_i);
                if (we_i) begin
                    ref_mem[addr_i[9:2]] = merge_bytes(ref_mem[addr_i[9:2]], wdata_i, be_i);
                end
            end
        end
    end

    // Protocol checker failures end the run at the next falling edge
    always @(negedge clk_i) begin
        if (i_obi_mem_subsys.i_obi_mem_subsys_sva.fail_cnt != 0) begin
            fail_run("The bound protocol checker flagged a failure");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("Watchdog expired before all responses came back");
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        seed    = 32'h62e0;
        clk_i   = 1'b0;
        rst_i   = 1'b1;
        req_i   = 1'b0;
        addr_i  = '0;
        we_i    = 1'b0;
        be_i    = '0;
        wdata_i = '0;
        repeat (RST_CYCLES) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        // Preload all words with banks interleaved to avoid recovery gaps
        for (int w = 0; w < `OBI_BANK_WORDS; w++) begin
            for (int b = 0; b < `OBI_NUM_BANKS; b++) begin
                issue(mk_addr(b, w), 1'b1, 4'hf, {mk_addr(b, w), ~mk_addr(b, w)});
            end
        end

        // Full word writes and then reads in every bank
        for (int b = 0; b < `OBI_NUM_BANKS; b++) begin
            rnd = $random(seed);
            word_sel[b] = int'(rnd[5:0]);
            issue(mk_addr(b, word_sel[b]), 1'b1, 4'hf, $random(seed));
        end
        for (int b = 0; b < `OBI_NUM_BANKS; b++) begin
            issue(mk_addr(b, word_sel[b]), 1'b0, 4'hf, '0);
        end

        // Byte enable merge
        issue(mk_addr(3, 9), 1'b1, 4'hf, 32'h1122_3344);
        issue(mk_addr(3, 9), 1'b1, 4'b0101, 32'haabb_ccdd);
        issue(mk_addr(3, 9), 1'b1, 4'b1000, 32'h5566_7788);
        issue(mk_addr(3, 9), 1'b0, 4'hf, '0);

        // Unmapped write and read followed by the aliased word
        issue(mk_addr(1, 7) | 16'h0400, 1'b1, 4'hf, 32'hdead_beef);
        issue(mk_addr(0, 2) | 16'h8000, 1'b0, 4'hf, '0);
        issue(mk_addr(1, 7), 1'b0, 4'hf, '0);

        // Write recovery on the same bank and on another bank
        idle();
        issue(mk_addr(2, 3), 1'b1, 4'hf, 32'h0bad_f00d);
        issue(mk_addr(2, 4), 1'b0, 4'hf, '0);
        assert (waits == 1)
        else fail_run($sformatf("Error: gnt_o low cycles expected %h actual %h", 1, waits));
        issue(mk_addr(1, 3), 1'b1, 4'hf, 32'h600d_cafe);
        issue(mk_addr(0, 3), 1'b0, 4'hf, '0);
        assert (waits == 0)
        else fail_run($sformatf("Error: gnt_o low cycles expected %h actual %h", 0, waits));

        // Back to back random reads with one accept per cycle
        idle();
        for (int n = 0; n < 16; n++) begin
            rnd = $random(seed);
            issue(obi_mem_pkg::obi_addr_t'({rnd[9:2], 2'b00}), 1'b0, 4'hf, '0);
            assert (waits == 0)
            else fail_run($sformatf("Error: gnt_o low cycles expected %h actual %h", 0, waits));
        end
        idle();

        while (exp_err_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (2) @(posedge clk_i);
        if (i_obi_mem_subsys.i_obi_mem_subsys_sva.fail_cnt == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            fail_run("The bound protocol checker flagged a failure");
        end
    end

endmodule : tb_obi_mem_subsys

/* vlog.f */
+incdir+include
hdl/obi_mem_pkg.sv
hdl/obi_addr_decoder.sv
hdl/obi_ram_bank.sv
hdl/obi_resp_mux.sv
hdl/obi_mem_subsys.sv
verification/obi_mem_subsys_sva.sv
verification/tb_obi_mem_subsys.sv

/* Makefile */
# Verilator build, run and lint for the OBI memory subsystem

VERILATOR  ?= verilator
TOP        := tb_obi_mem_subsys
RTL_TOP    := obi_mem_subsys
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/10ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --assert --timescale 1ns/10ps
PASS_MSG   := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
